/* hw/fxp_pkg.sv */
package fxp_pkg;

    // Q8.8 operand format
    localparam int FXP_INT_W  = 8;
    localparam int FXP_FRAC_W = 8;
    localparam int FXP_W      = FXP_INT_W + FXP_FRAC_W;

    // exact Q16.16 product and the sum of two of them
    localparam int FXP_PROD_W = 2 * FXP_W;
    localparam int FXP_SUM_W  = FXP_PROD_W + 1;

    // saturation limits of the Q8.8 result
    localparam int FXP_MAX = 2 ** (FXP_W - 1) - 1;
    localparam int FXP_MIN = -FXP_MAX - 1;

    // serial multiplier: one step per multiplier bit
    localparam int MUL_CYCLES = FXP_W;
    localparam int CNT_W      = $clog2(MUL_CYCLES);

    // operand queue, also the sender's starting credit count
    localparam int IN_DEPTH = 4;
    localparam int IN_PTR_W = $clog2(IN_DEPTH);

    // result slots granted by the consumer at reset
    localparam int OUT_CREDITS = 2;
    localparam int OUT_CNT_W   = $clog2(OUT_CREDITS + 1);

endpackage

/* hw/fxp_lane_if.sv */
`timescale 1ns/1ps

interface fxp_lane_if;
    import fxp_pkg::*;

    // start pulse and operand pair
    logic                    issue;
    logic signed [FXP_W-1:0] a;
    logic signed [FXP_W-1:0] b;

    logic busy;
    logic done;

    // exact Q16.16 result, held until the next issue
    logic signed [FXP_PROD_W-1:0] product;

    modport src (
        output issue,
        output a,
        output b,
        input  busy
    );

    modport mul (
        input  issue,
        input  a,
        input  b,
        output busy,
        output done,
        output product
    );

    modport sink (
        input done,
        input product
    );

endinterface

/* hw/fxp_serial_mul.sv */
`timescale 1ns/1ps

module fxp_serial_mul (
    input logic   clk,
    input logic   rst_n,
    fxp_lane_if.mul lane
);
    import fxp_pkg::*;

    // magnitudes one bit wider so that -32768 fits
    logic [FXP_W:0]          a_mag;
    logic [FXP_W:0]          b_mag;
    logic                    neg;
    logic signed [FXP_W:0]   a_ext;
    logic signed [FXP_W:0]   b_ext;
    logic [FXP_PROD_W-1:0]   acc;
    logic [FXP_PROD_W-1:0]   acc_next;
    logic [CNT_W-1:0]        cnt;
    logic                    busy;
    logic                    last_step;

    assign a_ext = {lane.a[FXP_W-1], lane.a};
    assign b_ext = {lane.b[FXP_W-1], lane.b};

    assign last_step = busy && (cnt == CNT_W'(MUL_CYCLES - 1));

    // shifted multiplicand added where the multiplier bit is set
    assign acc_next = b_mag[cnt] ? acc + (FXP_PROD_W'(a_mag) << cnt) : acc;

    assign lane.busy = busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            lane.done <= 1'b0;
            cnt       <= '0;
        end else begin
            lane.done <= 1'b0;
            if (lane.issue) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (last_step) begin
                busy      <= 1'b0;
                lane.done <= 1'b1;
                cnt       <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lane.issue) begin
            a_mag <= a_ext[FXP_W] ? -a_ext : a_ext;
            b_mag <= b_ext[FXP_W] ? -b_ext : b_ext;
            neg   <= lane.a[FXP_W-1] ^ lane.b[FXP_W-1];
            acc   <= '0;
        end else if (busy) begin
            acc <= acc_next;
        end
    end

    // sign goes back on the exact magnitude, no rounding here
    always_ff @(posedge clk) begin
        if (last_step) begin
            if (neg) begin
                lane.product <= -$signed(acc_next);
            end else begin
                lane.product <= $signed(acc_next);
            end
        end
    end

endmodule

/* hw/fxp_operand_queue.sv */
`timescale 1ns/1ps

module fxp_operand_queue (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  logic signed [fxp_pkg::FXP_W-1:0] in_a0,
    input  logic signed [fxp_pkg::FXP_W-1:0] in_b0,
    input  logic signed [fxp_pkg::FXP_W-1:0] in_a1,
    input  logic signed [fxp_pkg::FXP_W-1:0] in_b1,
    output logic                            in_credit,
    input  logic                            can_issue,
    fxp_lane_if.src                         lane0,
    fxp_lane_if.src                         lane1
);
    import fxp_pkg::*;

    // one entry holds a0, b0, a1, b1
    logic [4*FXP_W-1:0]  mem [IN_DEPTH];
    logic [IN_PTR_W-1:0] wr_ptr;
    logic [IN_PTR_W-1:0] rd_ptr;
    logic [IN_PTR_W:0]   count;
    logic                pop;
    logic                issue_q;

    // hold off while the previous issue pulse is still out
    assign pop = (count != '0) && !lane0.busy && !lane1.busy && can_issue && !issue_q;

    assign lane0.issue = issue_q;
    assign lane1.issue = issue_q;

    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= {in_a0, in_b0, in_a1, in_b1};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            issue_q   <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            issue_q   <= pop;
            in_credit <= pop;
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (in_valid && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !in_valid) begin
                count <= count - 1'b1;
            end
        end
    end

    // operands held stable alongside the issue pulse
    always_ff @(posedge clk) begin
        if (pop) begin
            lane0.a <= mem[rd_ptr][4*FXP_W-1:3*FXP_W];
            lane0.b <= mem[rd_ptr][3*FXP_W-1:2*FXP_W];
            lane1.a <= mem[rd_ptr][2*FXP_W-1:FXP_W];
            lane1.b <= mem[rd_ptr][FXP_W-1:0];
        end
    end

endmodule

/* hw/fxp_dot_combine.sv */
`timescale 1ns/1ps

module fxp_dot_combine (
    input  logic                            clk,
    input  logic                            rst_n,
    fxp_lane_if.sink                        lane0,
    fxp_lane_if.sink                        lane1,
    input  logic                            issued,
    input  logic                            out_credit,
    output logic                            can_issue,
    output logic                            out_valid,
    output logic signed [fxp_pkg::FXP_W-1:0] out_y
);
    import fxp_pkg::*;

    localparam int RND_W = FXP_SUM_W - FXP_FRAC_W;

    logic [OUT_CNT_W-1:0]        credits;
    logic signed [FXP_SUM_W-1:0] sum;
    logic [FXP_SUM_W-1:0]        mag;
    logic [RND_W-1:0]            rnd;
    logic signed [FXP_W-1:0]     y_sat;

    // output slots left for new jobs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= OUT_CNT_W'(OUT_CREDITS);
        end else if (issued && !out_credit) begin
            credits <= credits - 1'b1;
        end else if (out_credit && !issued) begin
            credits <= credits + 1'b1;
        end
    end

    assign can_issue = (credits != '0);

    // exact sum, then one rounding half away from zero
    assign sum = lane0.product + lane1.product;
    assign mag = sum[FXP_SUM_W-1] ? -sum : sum;
    assign rnd = mag[FXP_SUM_W-1:FXP_FRAC_W] + RND_W'(mag[FXP_FRAC_W-1]);

    always_comb begin
        if (sum[FXP_SUM_W-1]) begin
            if (rnd > RND_W'(FXP_MAX + 1)) begin
                y_sat = FXP_W'(FXP_MIN);
            end else begin
                y_sat = -$signed(rnd[FXP_W-1:0]);
            end
        end else begin
            if (rnd > RND_W'(FXP_MAX)) begin
                y_sat = FXP_W'(FXP_MAX);
            end else begin
                y_sat = $signed(rnd[FXP_W-1:0]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= lane0.done;
        end
    end

    always_ff @(posedge clk) begin
        if (lane0.done) begin
            out_y <= y_sat;
        end
    end

endmodule

/* hw/fxp_dot2.sv */
`timescale 1ns/1ps

module fxp_dot2 (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  logic signed [fxp_pkg::FXP_W-1:0] in_a0,
    input  logic signed [fxp_pkg::FXP_W-1:0] in_b0,
    input  logic signed [fxp_pkg::FXP_W-1:0] in_a1,
    input  logic signed [fxp_pkg::FXP_W-1:0] in_b1,
    output logic                            in_credit,
    output logic                            out_valid,
    output logic signed [fxp_pkg::FXP_W-1:0] out_y,
    input  logic                            out_credit
);

    fxp_lane_if lane0_if ();
    fxp_lane_if lane1_if ();

    logic can_issue;

    fxp_operand_queue queue_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_a0     (in_a0),
        .in_b0     (in_b0),
        .in_a1     (in_a1),
        .in_b1     (in_b1),
        .in_credit (in_credit),
        .can_issue (can_issue),
        .lane0     (lane0_if.src),
        .lane1     (lane1_if.src)
    );

    // both lanes start together and finish together
    fxp_serial_mul mul0_i (
        .clk   (clk),
        .rst_n (rst_n),
        .lane  (lane0_if.mul)
    );

    fxp_serial_mul mul1_i (
        .clk   (clk),
        .rst_n (rst_n),
        .lane  (lane1_if.mul)
    );

    fxp_dot_combine combine_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .lane0      (lane0_if.sink),
        .lane1      (lane1_if.sink),
        .issued     (lane0_if.issue),
        .out_credit (out_credit),
        .can_issue  (can_issue),
        .out_valid  (out_valid),
        .out_y      (out_y)
    );

endmodule

/* bench/fxp_dot2_assert.sv */
`timescale 1ns/1ps

module fxp_dot2_assert (
    input logic clk,
    input logic rst_n,
    input logic done0,
    input logic done1,
    input logic in_credit,
    input logic out_valid,
    input logic out_credit
);
    import fxp_pkg::*;

    // result slots the consumer has granted and not yet seen filled
    int slots;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slots <= OUT_CREDITS;
        end else if (out_valid && !out_credit) begin
            slots <= slots - 1;
        end else if (out_credit && !out_valid) begin
            slots <= slots + 1;
        end
    end

    credit_reserved: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> slots > 0
    ) else $error("out_valid without a reserved output credit");

    lanes_together: assert property (
        @(posedge clk) disable iff (!rst_n) done0 == done1
    ) else $error("done pulses of the two lanes differ");

    valid_after_done: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid == $past(done0)
    ) else $error("out_valid not exactly one cycle after done");

    quiet_in_reset: assert property (
        @(posedge clk) !rst_n |-> !in_credit && !out_valid
    ) else $error("in_credit or out_valid high during reset");

endmodule

bind fxp_dot2 fxp_dot2_assert assert_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .done0      (lane0_if.done),
    .done1      (lane1_if.done),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_credit (out_credit)
);

/* bench/fxp_dot2_tb.sv */
`timescale 1ns/1ps

module fxp_dot2_tb;
    import fxp_pkg::*;

    localparam int N_DIR = 10;
    localparam int N_BP  = 8;
    localparam int N_RND = 40;
    localparam int MAX_CYCLES = 40 * (N_DIR + N_BP + N_RND) + 4 * MUL_CYCLES + 100;
    localparam logic [31:0] SEED = 32'h6ab6_fc2c;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    in_valid;
    logic signed [FXP_W-1:0] in_a0;
    logic signed [FXP_W-1:0] in_b0;
    logic signed [FXP_W-1:0] in_a1;
    logic signed [FXP_W-1:0] in_b1;
    logic                    in_credit;
    logic                    out_valid;
    logic signed [FXP_W-1:0] out_y;
    logic                    out_credit;

    // a0, b0, a1, b1, expected y, all Q8.8
    logic [5*FXP_W-1:0] vec_tab [N_DIR] = '{
        {16'h0180, 16'h0200, 16'h0000, 16'h0000, 16'h0300},
        {16'hfe80, 16'h0200, 16'h0080, 16'hffc0, 16'hfce0},
        // ties on the sum, away from zero
        {16'h0003, 16'h0080, 16'h0000, 16'h0000, 16'h0002},
        {16'hfffd, 16'h0080, 16'h0000, 16'h0000, 16'hfffe},
        {16'h0001, 16'h0040, 16'h0001, 16'h0040, 16'h0001},
        {16'h7f00, 16'h7f00, 16'h7f00, 16'h7f00, 16'h7fff},
        {16'h8100, 16'h7f00, 16'h8100, 16'h7f00, 16'h8000},
        // large products that cancel
        {16'h7f00, 16'h7f00, 16'h8100, 16'h7e00, 16'h7f00},
        {16'h8000, 16'h0100, 16'h0000, 16'h0000, 16'h8000},
        {16'hfffd, 16'h0040, 16'h0000, 16'h0000, 16'hffff}
    };

    logic [5*FXP_W-1:0] send_q [$];
    logic [FXP_W-1:0]   exp_q [$];
    logic [31:0]        rng_stim = SEED;
    logic [31:0]        rng_sink = SEED;
    logic               hold_credits = 1'b0;
    int sent_cnt = 0;
    int ret_cnt = 0;
    int got_cnt = 0;
    int cred_ret = 0;
    int delay_left = 0;
    int cycles = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;

    fxp_dot2 fxp_dot2_i (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // exact sum, rounded once on the magnitude, then clamped
    function automatic logic [FXP_W-1:0] dot_model(input logic signed [FXP_W-1:0] a0, b0,
                                                   input logic signed [FXP_W-1:0] a1, b1);
        longint s;
        longint r;
        s = longint'(a0) * b0 + longint'(a1) * b1;
        r = ((s < 0 ? -s : s) + 2 ** (FXP_FRAC_W - 1)) >> FXP_FRAC_W;
        if (s < 0)
            r = -r;
        if (r > FXP_MAX)
            r = FXP_MAX;
        if (r < FXP_MIN)
            r = FXP_MIN;
        return r[FXP_W-1:0];
    endfunction

    task automatic check_value(input logic signed [31:0] actual,
                               input logic signed [31:0] expected, input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic draw_operand(output logic signed [FXP_W-1:0] v);
        rng_stim = xorshift32(rng_stim);
        // random shift so that not every sum saturates
        v = $signed(rng_stim[FXP_W-1:0]) >>> rng_stim[20:18];
    endtask

    task automatic wait_idle();
        while (send_q.size() != 0 || exp_q.size() != 0 || got_cnt != cred_ret)
            @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    // sender, spends one input credit per set
    always @(posedge clk) begin
        logic [5*FXP_W-1:0] vec;
        if (rst_n && send_q.size() != 0 && sent_cnt - ret_cnt < IN_DEPTH) begin
            vec = send_q.pop_front();
            {in_a0, in_b0, in_a1, in_b1} <= vec[5*FXP_W-1:FXP_W];
            in_valid <= 1'b1;
            sent_cnt++;
            exp_q.push_back(vec[FXP_W-1:0]);
        end else begin
            in_valid <= 1'b0;
        end
    end

    // sink hands slots back after a random delay
    always @(posedge clk) begin
        out_credit <= 1'b0;
        if (rst_n && !hold_credits && got_cnt > cred_ret) begin
            if (delay_left == 0) begin
                out_credit <= 1'b1;
                cred_ret++;
                rng_sink = xorshift32(rng_sink);
                delay_left = rng_sink[2:0];
            end else begin
                delay_left--;
            end
        end
    end

    always @(negedge clk) begin
        if (in_credit) begin
            ret_cnt++;
            if (ret_cnt > sent_cnt) begin
                $display("ERROR at %0t ns: in_credit returned with no set outstanding", $time);
                fail_cnt++;
            end
        end
        if (out_valid) begin
            got_cnt++;
            if (exp_q.size() == 0) begin
                $display("ERROR at %0t ns: out_valid with no result expected", $time);
                fail_cnt++;
            end else begin
                check_value(out_y, $signed(exp_q.pop_front()), "out_y");
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        logic signed [FXP_W-1:0] a0;
        logic signed [FXP_W-1:0] b0;
        logic signed [FXP_W-1:0] a1;
        logic signed [FXP_W-1:0] b1;
        int fails_before;
        int base_got;
        int base_sent;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_a0 = '0;
        in_b0 = '0;
        in_a1 = '0;
        in_b1 = '0;
        out_credit = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        fails_before = fail_cnt;
        foreach (vec_tab[i])
            send_q.push_back(vec_tab[i]);
        wait_idle();
        $display("test directed: %0d vectors, %0d errors", N_DIR, fail_cnt - fails_before);

        // sink keeps its slots, queue must fill and sender stall
        fails_before = fail_cnt;
        base_got = got_cnt;
        base_sent = sent_cnt;
        hold_credits = 1'b1;
        for (int i = 0; i < N_BP; i++)
            send_q.push_back(vec_tab[i]);
        while (got_cnt - base_got < OUT_CREDITS || sent_cnt - ret_cnt < IN_DEPTH)
            @(negedge clk);
        repeat (2 * MUL_CYCLES) @(negedge clk);
        check_value(got_cnt - base_got, OUT_CREDITS, "results while held");
        check_value(sent_cnt - ret_cnt, IN_DEPTH, "sets waiting in queue");
        check_value(sent_cnt - base_sent, IN_DEPTH + OUT_CREDITS, "sets accepted while held");
        hold_credits = 1'b0;
        wait_idle();
        $display("test back-pressure: %0d vectors, %0d errors", N_BP, fail_cnt - fails_before);

        fails_before = fail_cnt;
        for (int i = 0; i < N_RND; i++) begin
            draw_operand(a0);
            draw_operand(b0);
            draw_operand(a1);
            draw_operand(b1);
            send_q.push_back({a0, b0, a1, b1, dot_model(a0, b0, a1, b1)});
        end
        wait_idle();
        $display("test random: %0d vectors, %0d errors", N_RND, fail_cnt - fails_before);

        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

/* fxp_dot2.f */
hw/fxp_pkg.sv
hw/fxp_lane_if.sv
hw/fxp_serial_mul.sv
hw/fxp_operand_queue.sv
hw/fxp_dot_combine.sv
hw/fxp_dot2.sv
bench/fxp_dot2_assert.sv
bench/fxp_dot2_tb.sv
